//--- Bender.yml
package:
  name: frv_operand

sources:
  - frv_operand_pkg.sv
  - frv_gprs.sv
  - frv_hazard.sv
  - frv_operand_issue.sv
  - frv_operand_stage.sv
  - target: test
    files:
      - frv_operand_checker.sv
      - frv_operand_assert.sv
      - tb_frv_operand_stage.sv

//--- frv_gprs.sv
// -------------------------------------------------------------------------
// General purpose register file.
// Two combinational read ports, one write port, x0 hardwired to zero.
// -------------------------------------------------------------------------

`timescale 1ns/100ps

module frv_gprs (
    input  logic                                 g_clk,     // Global clock
    input  logic                                 rst,       // Sync reset
    input  logic [frv_operand_pkg::REG_ADDR_W-1:0] rs1_addr,  // Source 1 addr
    input  logic [frv_operand_pkg::REG_ADDR_W-1:0] rs2_addr,  // Source 2 addr
    output logic [frv_operand_pkg::XLEN-1:0]       rs1_rdata, // Source 1 data
    output logic [frv_operand_pkg::XLEN-1:0]       rs2_rdata, // Source 2 data
    input  logic                                 rd_wen,    // Write enable
    input  logic [frv_operand_pkg::REG_ADDR_W-1:0] rd_addr,   // Write address
    input  logic [frv_operand_pkg::XLEN-1:0]       rd_wdata   // Write data
);

    import frv_operand_pkg::*;

    // x0 has no storage, only x1 .. x31 are held
    logic [XLEN-1:0] regs [1:NUM_REGS-1];

    // ---------------------------------------------------------------------
    // Write port
    // ---------------------------------------------------------------------

    always_ff @(posedge g_clk) begin
        if (rst) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;                  // Start from a known state
            end
        end else if (rd_wen && (rd_addr != '0)) begin
            regs[rd_addr] <= rd_wdata;          // Writes to x0 dropped
        end
    end

    // ---------------------------------------------------------------------
    // Read ports
    // ---------------------------------------------------------------------

    // Old value is returned during a same-cycle write
    always_comb begin
        rs1_rdata = '0;                         // x0 reads zero
        rs2_rdata = '0;
        if (rs1_addr != '0) begin
            rs1_rdata = regs[rs1_addr];
        end
        if (rs2_addr != '0) begin
            rs2_rdata = regs[rs2_addr];
        end
    end

endmodule

//--- frv_hazard.sv
// -------------------------------------------------------------------------
// Hazard check of the two source registers against the s2, s3 and s4
// forwarding taps. Produces the operand select codes and the bubble
// request for a pending load or CSR read.
// -------------------------------------------------------------------------

`timescale 1ns/100ps

module frv_hazard (
    input  logic [frv_operand_pkg::REG_ADDR_W-1:0] rs1_addr,    // Source 1
    input  logic [frv_operand_pkg::REG_ADDR_W-1:0] rs2_addr,    // Source 2
    input  logic [frv_operand_pkg::REG_ADDR_W-1:0] fwd_s2_rd,   // Execute rd
    input  logic [frv_operand_pkg::REG_ADDR_W-1:0] fwd_s3_rd,   // Memory rd
    input  logic [frv_operand_pkg::REG_ADDR_W-1:0] fwd_s4_rd,   // Writeback rd
    input  logic                                 fwd_s2_load, // s2 data late
    input  logic                                 fwd_s3_load, // s3 data late
    input  logic                                 fwd_s4_load, // s4 data late
    output frv_operand_pkg::fwd_sel_t            rs1_sel,     // Source 1 pick
    output frv_operand_pkg::fwd_sel_t            rs2_sel,     // Source 2 pick
    output logic                                 bubble       // Hold stage 1
);

    import frv_operand_pkg::*;

    // ---------------------------------------------------------------------
    // Address matches
    // ---------------------------------------------------------------------

    logic nz_rs1;                               // rs1 is not x0
    logic nz_rs2;                               // rs2 is not x0

    logic hzd_rs1_s2, hzd_rs1_s3, hzd_rs1_s4;
    logic hzd_rs2_s2, hzd_rs2_s3, hzd_rs2_s4;

    logic late_rs1;                             // Chosen rs1 tap not ready
    logic late_rs2;                             // Chosen rs2 tap not ready

    assign nz_rs1 = |rs1_addr;
    assign nz_rs2 = |rs2_addr;

    // A zero rd can only hit a zero source, so it never matches
    assign hzd_rs1_s2 = nz_rs1 && (rs1_addr == fwd_s2_rd);
    assign hzd_rs1_s3 = nz_rs1 && (rs1_addr == fwd_s3_rd);
    assign hzd_rs1_s4 = nz_rs1 && (rs1_addr == fwd_s4_rd);

    assign hzd_rs2_s2 = nz_rs2 && (rs2_addr == fwd_s2_rd);
    assign hzd_rs2_s3 = nz_rs2 && (rs2_addr == fwd_s3_rd);
    assign hzd_rs2_s4 = nz_rs2 && (rs2_addr == fwd_s4_rd);

    // ---------------------------------------------------------------------
    // Youngest match wins
    // ---------------------------------------------------------------------

    always_comb begin
        rs1_sel  = FWD_GPR;
        late_rs1 = 1'b0;
        if (hzd_rs1_s2) begin
            rs1_sel  = FWD_S2;
            late_rs1 = fwd_s2_load;
        end else if (hzd_rs1_s3) begin
            rs1_sel  = FWD_S3;
            late_rs1 = fwd_s3_load;
        end else if (hzd_rs1_s4) begin
            rs1_sel  = FWD_S4;
            late_rs1 = fwd_s4_load;
        end
    end

    always_comb begin
        rs2_sel  = FWD_GPR;
        late_rs2 = 1'b0;
        if (hzd_rs2_s2) begin
            rs2_sel  = FWD_S2;
            late_rs2 = fwd_s2_load;
        end else if (hzd_rs2_s3) begin
            rs2_sel  = FWD_S3;
            late_rs2 = fwd_s3_load;
        end else if (hzd_rs2_s4) begin
            rs2_sel  = FWD_S4;
            late_rs2 = fwd_s4_load;
        end
    end

    // Older ready taps are shadowed by a younger late one
    assign bubble = late_rs1 || late_rs2;

endmodule

//--- frv_operand.f
frv_operand_pkg.sv
frv_gprs.sv
frv_hazard.sv
frv_operand_issue.sv
frv_operand_stage.sv
frv_operand_checker.sv
frv_operand_assert.sv
tb_frv_operand_stage.sv

//--- frv_operand_assert.sv
// --------------------------------------------------------------------------
// Concurrent assertions bound into the operand stage top level.
// Back-pressure hold, valid after reset and the x0 operand rule.
// --------------------------------------------------------------------------

`timescale 1ns/100ps

module frv_operand_assert (
    input logic                                   g_clk,
    input logic                                   rst,
    input logic                                   flush,
    input logic                                   s2_valid,
    input logic                                   s2_busy,
    input logic [frv_operand_pkg::XLEN-1:0]       s2_rs1_data,
    input logic [frv_operand_pkg::XLEN-1:0]       s2_rs2_data,
    input logic [frv_operand_pkg::REG_ADDR_W-1:0] s2_rd,
    input logic [31:0]                            s2_instr
);

    int fail_count = 0;                                         // Read by the top

    // Payload frozen while the sink stalls
    hold_payload: assert property (@(posedge g_clk) disable iff (rst)
        s2_valid && s2_busy |=> $stable(s2_rs1_data) && $stable(s2_rs2_data)
                                && $stable(s2_rd) && $stable(s2_instr))
        else begin
            fail_count++;
            $error("stage 2 payload changed under back-pressure");
        end

    hold_valid: assert property (@(posedge g_clk) disable iff (rst)
        s2_valid && s2_busy && !flush |=> s2_valid)
        else begin
            fail_count++;
            $error("stage 2 item dropped under back-pressure");
        end

    reset_valid: assert property (@(posedge g_clk) rst |=> !s2_valid)
        else begin
            fail_count++;
            $error("s2_valid high after reset");
        end

    // Bits 19:15 hold rs1 in both views
    zero_rs1: assert property (@(posedge g_clk) disable iff (rst)
        s2_valid && (s2_instr[19:15] == '0) |-> s2_rs1_data == '0)
        else begin
            fail_count++;
            $error("operand 1 of an x0 source is not zero");
        end

endmodule

//--- frv_operand_checker.sv
// --------------------------------------------------------------------------
// Scoreboard for the operand stage.
// Register file model, forwarding priority and hazard rule, expected item
// queue and the comparison of every consumed stage 2 item.
// --------------------------------------------------------------------------

`timescale 1ns/100ps

module frv_operand_checker (
    input  logic                                   g_clk,
    input  logic                                   rst,
    input  logic                                   flush,
    input  logic                                   s1_valid,
    input  logic                                   s1_busy,
    input  logic [31:0]                            s1_instr,
    input  logic                                   s2_valid,
    input  logic                                   s2_busy,
    input  logic [frv_operand_pkg::XLEN-1:0]       s2_rs1_data,
    input  logic [frv_operand_pkg::XLEN-1:0]       s2_rs2_data,
    input  logic [frv_operand_pkg::REG_ADDR_W-1:0] s2_rd,
    input  logic [31:0]                            s2_instr,
    input  logic [frv_operand_pkg::REG_ADDR_W-1:0] fwd_s2_rd, fwd_s3_rd, fwd_s4_rd,
    input  logic [frv_operand_pkg::XLEN-1:0]       fwd_s2_wdata, fwd_s3_wdata, fwd_s4_wdata,
    input  logic                                   fwd_s2_load, fwd_s3_load, fwd_s4_load,
    input  logic                                   gpr_wen,
    input  logic [frv_operand_pkg::REG_ADDR_W-1:0] gpr_rd,
    input  logic [frv_operand_pkg::XLEN-1:0]       gpr_wdata,
    output int                                     errors,
    output int                                     checks
);

    import frv_operand_pkg::*;

    logic [XLEN-1:0]       regs [NUM_REGS];                     // GPR model
    logic [XLEN-1:0]       exp_rs1_q [$];
    logic [XLEN-1:0]       exp_rs2_q [$];
    logic [REG_ADDR_W-1:0] exp_rd_q [$];
    logic [31:0]           exp_instr_q [$];
    int                    err_cnt = 0;
    int                    chk_cnt = 0;

    assign errors = err_cnt;
    assign checks = chk_cnt;

    task automatic report(input string name, input logic [31:0] exp, input logic [31:0] got);
        $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, got);
        err_cnt++;
    endtask

    // Youngest matching tap first and the register file last
    task automatic resolve(input logic [REG_ADDR_W-1:0] rs, output logic [XLEN-1:0] data,
                           output logic late);
        data = '0;                                              // x0 reads zero
        late = 1'b0;
        if (rs != '0) begin
            if (rs == fwd_s2_rd) begin
                data = fwd_s2_wdata;
                late = fwd_s2_load;
            end else if (rs == fwd_s3_rd) begin
                data = fwd_s3_wdata;
                late = fwd_s3_load;
            end else if (rs == fwd_s4_rd) begin
                data = fwd_s4_wdata;
                late = fwd_s4_load;
            end else begin
                data = regs[rs];
            end
        end
    endtask

    // ----------------------------------------------------------------------
    // Sampled mid-cycle where inputs and outputs have settled
    // ----------------------------------------------------------------------

    always @(negedge g_clk) begin
        instr_word_u           w;
        logic [REG_ADDR_W-1:0] rs1, rs2;
        logic [XLEN-1:0]       d1, d2;
        logic                  l1, l2;
        logic                  exp_valid;
        logic                  busy_exp;
        w = s1_instr;
        if (rst) begin
            foreach (regs[i]) regs[i] = '0;
            exp_rs1_q.delete();
            exp_rs2_q.delete();
            exp_rd_q.delete();
            exp_instr_q.delete();
        end else begin
            rs1 = w.i.rs1;
            rs2 = (w.r.opcode == OPC_OP) ? w.r.rs2 : '0;        // I-type has no rs2
            resolve(rs1, d1, l1);
            resolve(rs2, d2, l2);
            exp_valid = exp_rd_q.size() != 0;                   // Model stage 2 full
            busy_exp  = l1 || l2 || (exp_valid && s2_busy);
            if (s1_busy !== busy_exp) report("s1_busy", busy_exp, s1_busy);
            if (s2_valid !== exp_valid) report("s2_valid", exp_valid, s2_valid);
            if (flush) begin                                    // Held and new dropped
                exp_rs1_q.delete();
                exp_rs2_q.delete();
                exp_rd_q.delete();
                exp_instr_q.delete();
            end else begin
                if (exp_valid && !s2_busy) begin
                    if (s2_rs1_data !== exp_rs1_q[0]) begin
                        report("s2_rs1_data", exp_rs1_q[0], s2_rs1_data);
                    end
                    if (s2_rs2_data !== exp_rs2_q[0]) begin
                        report("s2_rs2_data", exp_rs2_q[0], s2_rs2_data);
                    end
                    if (s2_rd !== exp_rd_q[0]) report("s2_rd", exp_rd_q[0], s2_rd);
                    if (s2_instr !== exp_instr_q[0]) begin
                        report("s2_instr", exp_instr_q[0], s2_instr);
                    end
                    void'(exp_rs1_q.pop_front());
                    void'(exp_rs2_q.pop_front());
                    void'(exp_rd_q.pop_front());
                    void'(exp_instr_q.pop_front());
                    chk_cnt++;
                end
                if (s1_valid && !busy_exp) begin                // Accepted this cycle
                    exp_rs1_q.push_back(d1);
                    exp_rs2_q.push_back(d2);
                    exp_rd_q.push_back(w.r.rd);
                    exp_instr_q.push_back(w);
                end
            end
            if (gpr_wen && gpr_rd != '0) regs[gpr_rd] = gpr_wdata;  // Lands at next edge
        end
    end

endmodule

//--- frv_operand_issue.sv
// -------------------------------------------------------------------------
// Operand issue stage.
// Picks forwarded or register data per source and holds the stage 2
// register with its valid/busy handshake and flush.
// -------------------------------------------------------------------------

`timescale 1ns/100ps

module frv_operand_issue (
    input  logic                                 g_clk,        // Global clock
    input  logic                                 rst,          // Sync reset
    input  logic                                 flush,        // Drop stage
    input  logic                                 s1_valid,     // Input valid
    output logic                                 s1_busy,      // Input stall
    input  logic                                 bubble,       // Late operand
    input  frv_operand_pkg::fwd_sel_t            rs1_sel,      // Source 1 pick
    input  frv_operand_pkg::fwd_sel_t            rs2_sel,      // Source 2 pick
    input  logic [frv_operand_pkg::XLEN-1:0]       rs1_rdata,    // GPR rs1
    input  logic [frv_operand_pkg::XLEN-1:0]       rs2_rdata,    // GPR rs2
    input  logic [frv_operand_pkg::XLEN-1:0]       fwd_s2_wdata, // Execute data
    input  logic [frv_operand_pkg::XLEN-1:0]       fwd_s3_wdata, // Memory data
    input  logic [frv_operand_pkg::XLEN-1:0]       fwd_s4_wdata, // Writeback data
    input  logic [frv_operand_pkg::REG_ADDR_W-1:0] s1_rd,        // Destination
    input  logic [31:0]                          s1_instr,     // Raw word
    output logic                                 s2_valid,     // Output valid
    input  logic                                 s2_busy,      // Sink stall
    output logic [frv_operand_pkg::XLEN-1:0]       s2_rs1_data,  // Operand 1
    output logic [frv_operand_pkg::XLEN-1:0]       s2_rs2_data,  // Operand 2
    output logic [frv_operand_pkg::REG_ADDR_W-1:0] s2_rd,        // Destination
    output logic [31:0]                          s2_instr      // Raw word
);

    import frv_operand_pkg::*;

    logic            accept;                    // Stage 1 handshake fires
    logic [XLEN-1:0] opr_rs1;                   // Selected operand 1
    logic [XLEN-1:0] opr_rs2;                   // Selected operand 2

    // ---------------------------------------------------------------------
    // Operand select
    // ---------------------------------------------------------------------

    function automatic logic [XLEN-1:0] pick_operand(
        input fwd_sel_t        sel,
        input logic [XLEN-1:0] gpr
    );
        case (sel)
            FWD_S2:  return fwd_s2_wdata;       // Youngest result
            FWD_S3:  return fwd_s3_wdata;
            FWD_S4:  return fwd_s4_wdata;
            default: return gpr;                // No tap matched
        endcase
    endfunction

    assign opr_rs1 = pick_operand(rs1_sel, rs1_rdata);
    assign opr_rs2 = pick_operand(rs2_sel, rs2_rdata);

    // ---------------------------------------------------------------------
    // Handshake
    // ---------------------------------------------------------------------

    // Stall on a late operand, or while a held item is not consumed
    assign s1_busy = bubble || (s2_valid && s2_busy);
    assign accept  = s1_valid && !s1_busy;

    always_ff @(posedge g_clk) begin
        if (rst) begin
            s2_valid <= 1'b0;
        end else if (flush) begin
            s2_valid <= 1'b0;                   // Held and new item dropped
        end else if (accept) begin
            s2_valid <= 1'b1;
        end else if (!s2_busy) begin
            s2_valid <= 1'b0;                   // Consumed, nothing new
        end
    end

    // Payload only moves on accept, so it holds under back-pressure
    always_ff @(posedge g_clk) begin
        if (accept) begin
            s2_rs1_data <= opr_rs1;
            s2_rs2_data <= opr_rs2;
            s2_rd       <= s1_rd;
            s2_instr    <= s1_instr;
        end
    end

endmodule

//--- frv_operand_pkg.sv
// -------------------------------------------------------------------------
// Shared definitions for the operand stage.
// Word and register address widths, the opcodes that are decoded, the
// operand source select codes and the instruction word union.
// -------------------------------------------------------------------------

package frv_operand_pkg;

    // ---------------------------------------------------------------------
    // Widths
    // ---------------------------------------------------------------------

    localparam int XLEN       = 32;             // Data word width
    localparam int REG_ADDR_W = 5;              // GPR address width
    localparam int NUM_REGS   = 32;             // x0 .. x31

    // ---------------------------------------------------------------------
    // Opcodes
    // ---------------------------------------------------------------------

    localparam logic [6:0] OPC_OP     = 7'b0110011; // R-type ALU ops
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011; // I-type ALU ops

    // Where an operand comes from, youngest tap first
    typedef enum logic [1:0] {
        FWD_GPR = 2'd0,                         // Register file read
        FWD_S2  = 2'd1,                         // Execute stage tap
        FWD_S3  = 2'd2,                         // Memory stage tap
        FWD_S4  = 2'd3                          // Writeback stage tap
    } fwd_sel_t;

    // ---------------------------------------------------------------------
    // Instruction word views
    // ---------------------------------------------------------------------

    typedef struct packed {
        logic [6:0]            funct7;          // Upper function bits
        logic [REG_ADDR_W-1:0] rs2;             // Source 2
        logic [REG_ADDR_W-1:0] rs1;             // Source 1
        logic [2:0]            funct3;          // Lower function bits
        logic [REG_ADDR_W-1:0] rd;              // Destination
        logic [6:0]            opcode;          // Major opcode
    } instr_r_t;

    typedef struct packed {
        logic [11:0]           imm12;           // Covers the rs2 field too
        logic [REG_ADDR_W-1:0] rs1;             // Source 1
        logic [2:0]            funct3;          // Lower function bits
        logic [REG_ADDR_W-1:0] rd;              // Destination
        logic [6:0]            opcode;          // Major opcode
    } instr_i_t;

    // Same 32 bits, read as R-type or I-type
    typedef union packed {
        instr_r_t r;                            // Register-register view
        instr_i_t i;                            // Register-immediate view
    } instr_word_u;

endpackage

//--- frv_operand_stage.sv
// -------------------------------------------------------------------------
// Operand stage top level.
// Decodes the register fields of the instruction word and connects the
// register file, the hazard unit and the issue stage.
// -------------------------------------------------------------------------

`timescale 1ns/100ps

module frv_operand_stage (
    input  logic                                 g_clk,        // Global clock
    input  logic                                 rst,          // Sync reset
    input  logic                                 flush,        // Drop stage
    input  logic                                 s1_valid,     // Input valid
    output logic                                 s1_busy,      // Input stall
    input  frv_operand_pkg::instr_word_u         s1_instr,     // Instruction
    output logic                                 s2_valid,     // Output valid
    input  logic                                 s2_busy,      // Sink stall
    output logic [frv_operand_pkg::XLEN-1:0]       s2_rs1_data,  // Operand 1
    output logic [frv_operand_pkg::XLEN-1:0]       s2_rs2_data,  // Operand 2
    output logic [frv_operand_pkg::REG_ADDR_W-1:0] s2_rd,        // Destination
    output logic [31:0]                          s2_instr,     // Raw word
    input  logic [frv_operand_pkg::REG_ADDR_W-1:0] fwd_s2_rd,    // Execute tap
    input  logic [frv_operand_pkg::XLEN-1:0]       fwd_s2_wdata,
    input  logic                                 fwd_s2_load,
    input  logic [frv_operand_pkg::REG_ADDR_W-1:0] fwd_s3_rd,    // Memory tap
    input  logic [frv_operand_pkg::XLEN-1:0]       fwd_s3_wdata,
    input  logic                                 fwd_s3_load,
    input  logic [frv_operand_pkg::REG_ADDR_W-1:0] fwd_s4_rd,    // Writeback tap
    input  logic [frv_operand_pkg::XLEN-1:0]       fwd_s4_wdata,
    input  logic                                 fwd_s4_load,
    input  logic                                 gpr_wen,      // GPR write
    input  logic [frv_operand_pkg::REG_ADDR_W-1:0] gpr_rd,
    input  logic [frv_operand_pkg::XLEN-1:0]       gpr_wdata
);

    import frv_operand_pkg::*;

    // ---------------------------------------------------------------------
    // Register field decode
    // ---------------------------------------------------------------------

    logic                  is_op;               // R-type word
    logic                  is_op_imm;           // I-type word
    logic                  uses_rs2;            // rs2 field is a register
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [REG_ADDR_W-1:0] s1_rd;
    logic [XLEN-1:0]       rs1_rdata;
    logic [XLEN-1:0]       rs2_rdata;
    fwd_sel_t              rs1_sel;
    fwd_sel_t              rs2_sel;
    logic                  bubble;

    assign is_op     = s1_instr.r.opcode == OPC_OP;
    assign is_op_imm = s1_instr.i.opcode == OPC_OP_IMM;
    assign uses_rs2  = is_op;

    // Other opcodes read no sources and raise no hazard
    assign rs1_addr = (is_op || is_op_imm) ? s1_instr.i.rs1 : '0;
    // Immediate bits in the rs2 slot must not look like a source
    assign rs2_addr = uses_rs2 ? s1_instr.r.rs2 : '0;
    assign s1_rd    = s1_instr.r.rd;

    // ---------------------------------------------------------------------
    // Submodules
    // ---------------------------------------------------------------------

    frv_gprs i_gprs (
        .g_clk     (g_clk),
        .rst       (rst),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_rdata (rs1_rdata),
        .rs2_rdata (rs2_rdata),
        .rd_wen    (gpr_wen),
        .rd_addr   (gpr_rd),
        .rd_wdata  (gpr_wdata)
    );

    frv_hazard i_hazard (
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .fwd_s2_rd   (fwd_s2_rd),
        .fwd_s3_rd   (fwd_s3_rd),
        .fwd_s4_rd   (fwd_s4_rd),
        .fwd_s2_load (fwd_s2_load),
        .fwd_s3_load (fwd_s3_load),
        .fwd_s4_load (fwd_s4_load),
        .rs1_sel     (rs1_sel),
        .rs2_sel     (rs2_sel),
        .bubble      (bubble)
    );

    frv_operand_issue i_issue (
        .g_clk        (g_clk),
        .rst          (rst),
        .flush        (flush),
        .s1_valid     (s1_valid),
        .s1_busy      (s1_busy),
        .bubble       (bubble),
        .rs1_sel      (rs1_sel),
        .rs2_sel      (rs2_sel),
        .rs1_rdata    (rs1_rdata),
        .rs2_rdata    (rs2_rdata),
        .fwd_s2_wdata (fwd_s2_wdata),
        .fwd_s3_wdata (fwd_s3_wdata),
        .fwd_s4_wdata (fwd_s4_wdata),
        .s1_rd        (s1_rd),
        .s1_instr     (s1_instr),             // Union flattens to 32 bits
        .s2_valid     (s2_valid),
        .s2_busy      (s2_busy),
        .s2_rs1_data  (s2_rs1_data),
        .s2_rs2_data  (s2_rs2_data),
        .s2_rd        (s2_rd),
        .s2_instr     (s2_instr)
    );

endmodule

//--- tb_frv_operand_stage.sv
// --------------------------------------------------------------------------
// Testbench top for the operand stage.
// Clock and reset, seeded random stimulus on the stage 1 port, the taps and
// the GPR write port, watchdog, bound assertions and the closing result.
// --------------------------------------------------------------------------

`timescale 1ns/100ps

module tb_frv_operand_stage;

    import frv_operand_pkg::*;

    localparam int  RUN_CYCLES      = 2000;                     // Random cycles
    localparam int  WATCHDOG_CYCLES = RUN_CYCLES + RUN_CYCLES / 10;
    localparam time CLK_PERIOD      = 100ns;

    logic                  g_clk;
    logic                  rst;
    logic                  flush;
    logic                  s1_valid;
    logic                  s1_busy;
    instr_word_u           s1_instr;
    logic                  s2_valid;
    logic                  s2_busy;
    logic [XLEN-1:0]       s2_rs1_data;
    logic [XLEN-1:0]       s2_rs2_data;
    logic [REG_ADDR_W-1:0] s2_rd;
    logic [31:0]           s2_instr;
    logic [REG_ADDR_W-1:0] fwd_s2_rd, fwd_s3_rd, fwd_s4_rd;
    logic [XLEN-1:0]       fwd_s2_wdata, fwd_s3_wdata, fwd_s4_wdata;
    logic                  fwd_s2_load, fwd_s3_load, fwd_s4_load;
    logic                  gpr_wen;
    logic [REG_ADDR_W-1:0] gpr_rd;
    logic [XLEN-1:0]       gpr_wdata;
    int                    seed;                                // Random state
    int                    errors;                              // From checker
    int                    checks;                              // Items compared

    frv_operand_stage DUT (.*);

    frv_operand_checker i_checker (.*);

    bind frv_operand_stage frv_operand_assert i_assert (
        .g_clk (g_clk), .rst (rst), .flush (flush), .s2_valid (s2_valid),
        .s2_busy (s2_busy), .s2_rs1_data (s2_rs1_data), .s2_rs2_data (s2_rs2_data),
        .s2_rd (s2_rd), .s2_instr (s2_instr)
    );

    // True with a probability of pct percent
    function automatic logic chance(input int pct);
        int r;
        r = $random(seed);
        return ((r & 32'h7fff_ffff) % 100) < pct;
    endfunction

    // Small register index so taps and sources collide often
    function automatic logic [REG_ADDR_W-1:0] pick_reg(input int mask);
        int r;
        r = $random(seed);
        return REG_ADDR_W'(r & mask);
    endfunction

    // ----------------------------------------------------------------------
    // One cycle of stimulus, called right after a rising edge
    // ----------------------------------------------------------------------

    task automatic drive_inputs();
        instr_word_u nxt;
        nxt = s1_instr;
        if (!(s1_valid && s1_busy && !flush)) begin            // Else hold word
            nxt          = $random(seed);
            nxt.r.opcode = chance(50) ? OPC_OP : OPC_OP_IMM;
            nxt.r.rs1    = pick_reg(7);
            nxt.r.rs2    = pick_reg(7);                         // Imm bits if I-type
            s1_valid    <= chance(75);
        end
        s1_instr     <= nxt;
        fwd_s2_rd    <= pick_reg(3);
        fwd_s2_wdata <= $random(seed);
        fwd_s2_load  <= chance(20);
        fwd_s3_rd    <= pick_reg(3);
        fwd_s3_wdata <= $random(seed);
        fwd_s3_load  <= chance(20);
        fwd_s4_rd    <= pick_reg(3);
        fwd_s4_wdata <= $random(seed);
        fwd_s4_load  <= chance(20);
        gpr_wen      <= chance(30);
        gpr_rd       <= pick_reg(7);
        gpr_wdata    <= $random(seed);
        s2_busy      <= chance(25);
        flush        <= chance(5);
    endtask

    initial begin
        g_clk = 1'b0;
        forever #(CLK_PERIOD / 2) g_clk = ~g_clk;
    end

    initial begin
        #(CLK_PERIOD * WATCHDOG_CYCLES);
        $display("Watchdog expired after %0d cycles, run did not drain", WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        seed = 32'h4c61c7b3;
        rst = 1'b1;
        flush = 1'b0;
        s1_valid = 1'b0;
        s1_instr = '0;
        s2_busy = 1'b0;
        {fwd_s2_rd, fwd_s3_rd, fwd_s4_rd} = '0;
        {fwd_s2_wdata, fwd_s3_wdata, fwd_s4_wdata} = '0;
        {fwd_s2_load, fwd_s3_load, fwd_s4_load} = '0;
        gpr_wen = 1'b0;
        gpr_rd = '0;
        gpr_wdata = '0;
        repeat (2) @(posedge g_clk);
        rst <= 1'b0;
        for (int c = 0; c < RUN_CYCLES; c++) begin
            @(posedge g_clk);
            drive_inputs();
        end
        // Drain with no new work and no stalls until the last item leaves
        @(posedge g_clk);
        s1_valid <= 1'b0;
        s2_busy  <= 1'b0;
        flush    <= 1'b0;
        {fwd_s2_load, fwd_s3_load, fwd_s4_load} <= '0;
        @(negedge g_clk);
        while (s2_valid) @(negedge g_clk);
        @(posedge g_clk);
        #(CLK_PERIOD / 4);                                      // Past checker and assertions
        $display("Compared %0d items, %0d checker errors, %0d assertion errors",
                 checks, errors, DUT.i_assert.fail_count);
        if (errors == 0 && DUT.i_assert.fail_count == 0 && checks > 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
